//--- bench/msx_slots_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "msx_defines.svh"

module msx_slots_props (
   input logic        clk,
   input logic        reset,
   input logic [1:0]  active_slot,
   input logic [3:0]  expander_en,
   input logic [15:0] cpu_addr,
   input logic        cpu_mreq,
   input logic        ram_ce,
   input logic        ram_we
);

   logic exp_access;

   // secondary slot register cycle of the active slot
   assign exp_access = cpu_mreq && (cpu_addr == `MSX_EXPANDER_ADDR) && expander_en[active_slot];

   ce_needs_mreq: assert property (@(posedge clk) disable iff (reset) ram_ce |-> cpu_mreq)
      else $error("ram_ce high outside a memory cycle");

   we_needs_ce: assert property (@(posedge clk) disable iff (reset) ram_we |-> ram_ce)
      else $error("ram_we high without ram_ce");

   expander_no_ce: assert property (@(posedge clk) disable iff (reset) exp_access |-> !ram_ce)
      else $error("expander access reached external memory");

endmodule

bind msx_slots msx_slots_props i_msx_slots_props (.*);

`default_nettype wire

//--- bench/msx_slots_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "msx_defines.svh"

module msx_slots_tb
   import msx_pkg::*;
();

   localparam int CLK_HALF     = 20;
   localparam int DRIVE_DELAY  = 2;
   localparam int SAMPLE_DELAY = 10;
   localparam int RUN_CYCLES   = 2000;

   logic         clk;
   logic         reset;
   logic [1:0]   active_slot;
   logic [3:0]   expander_en;
   logic [15:0]  cpu_addr;
   logic [7:0]   cpu_dout;
   logic         cpu_wr;
   logic         cpu_rd;
   logic         cpu_mreq;
   logic [7:0]   cpu_din;
   logic         cfg_wr;
   logic         cfg_region;
   logic [5:0]   cfg_index;
   region_word_t cfg_data;
   ram_addr_t    ram_addr;
   logic [7:0]   ram_din;
   logic [7:0]   ram_dout;
   logic         ram_ce;
   logic         ram_we;

   // reference copies of tables and registers
   layout_word_t layout_m [0:63];
   region_word_t region_m [0:3];
   logic [7:0]   sub_m [0:3];
   bank_t        konami_m [0:2];
   bank_t        ascii8_m [0:3];

   integer       seed;
   int           checks;
   int           errors;
   int           checks_at_start;
   int           errors_at_start;
   int           i;
   int           n;
   logic [5:0]   idx;
   layout_word_t word;
   logic [31:0]  rnd;
   logic [15:0]  a;
   logic         w;

   function automatic logic [7:0] mem_hash(input ram_addr_t addr);
      logic [23:0] x;
      x = {addr, 2'b01} * 24'h9E37B5;
      return x[23:16] ^ x[15:8] ^ addr[7:0];
   endfunction

   // external memory model
   assign ram_dout = mem_hash(ram_addr);

   msx_slots i_msx_slots (
      .clk         (clk),
      .reset       (reset),
      .active_slot (active_slot),
      .expander_en (expander_en),
      .cpu_addr    (cpu_addr),
      .cpu_dout    (cpu_dout),
      .cpu_wr      (cpu_wr),
      .cpu_rd      (cpu_rd),
      .cpu_mreq    (cpu_mreq),
      .cpu_din     (cpu_din),
      .cfg_wr      (cfg_wr),
      .cfg_region  (cfg_region),
      .cfg_index   (cfg_index),
      .cfg_data    (cfg_data),
      .ram_addr    (ram_addr),
      .ram_din     (ram_din),
      .ram_dout    (ram_dout),
      .ram_ce      (ram_ce),
      .ram_we      (ram_we)
   );

   always #CLK_HALF clk = ~clk;

   initial begin
      #(RUN_CYCLES * 2 * CLK_HALF);
      $display("timeout: the run did not complete in time");
      $display("** FAIL **");
      $finish;
   end

   task automatic wait_clocks(input int count);
      int  k;
      time t0;
      t0 = $time;
      k = 0;
      while (k < count) begin
         @(posedge clk);
         k++;
         if ($time - t0 > (count + 1) * 2 * CLK_HALF) begin
            $display("timeout: clock edges arrived too late");
            errors++;
            k = count;
         end
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic start_test();
      checks_at_start = checks;
      errors_at_start = errors;
   endtask

   task automatic finish_test(input int num, input string name);
      $display("test %0d %s: %0d checks, %0d errors", num, name,
               checks - checks_at_start, errors - errors_at_start);
   endtask

   task automatic load_entry(input logic region, input logic [5:0] index,
                             input region_word_t data);
      wait_clocks(1);
      #DRIVE_DELAY;
      cpu_mreq   = 1'b0;
      cfg_wr     = 1'b1;
      cfg_region = region;
      cfg_index  = index;
      cfg_data   = data;
      if (region) begin
         region_m[index[1:0]] = data;
      end else begin
         layout_m[index] = data[6:0];
      end
   endtask

   // one cpu cycle, checked against the model, then model state update
   task automatic access(input logic [1:0] slot, input logic [15:0] addr,
                         input logic [7:0] data, input logic wr, input logic rd,
                         input logic mreq);
      logic [1:0]   blk;
      logic [1:0]   sub;
      logic         exp_acc;
      layout_word_t lw;
      logic [2:0]   mtype;
      region_word_t rw;
      logic [7:0]   size;
      logic [7:0]   bank;
      logic [21:0]  offs;
      logic [21:0]  exp_addr;
      logic         mapped;
      logic         exp_ce;
      logic [7:0]   exp_din;

      wait_clocks(1);
      #DRIVE_DELAY;
      cfg_wr      = 1'b0;
      active_slot = slot;
      cpu_addr    = addr;
      cpu_dout    = data;
      cpu_wr      = wr;
      cpu_rd      = rd;
      cpu_mreq    = mreq;

      blk     = addr[15:14];
      exp_acc = mreq && (addr == 16'hFFFF) && expander_en[slot];
      sub     = expander_en[slot] ? sub_m[slot][2 * blk +: 2] : 2'd0;
      lw      = layout_m[{slot, sub, blk}];
      mtype   = lw[6:4];
      rw      = region_m[lw[3:2]];
      size    = rw[15:8];
      bank    = 8'h00;
      mapped  = 1'b1;
      offs    = '0;
      case (mtype)
         MAPPER_NONE:   offs = lw[1:0] * 22'h4000 + addr[13:0];
         MAPPER_LINEAR: offs = addr & (size * 22'h4000 - 1);
         MAPPER_KONAMI: begin
            mapped = addr >= 16'h4000 && addr < 16'hC000;
            if (addr >= 16'h6000 && addr < 16'h8000) begin
               bank = konami_m[0];
            end else if (addr >= 16'h8000 && addr < 16'hA000) begin
               bank = konami_m[1];
            end else if (addr >= 16'hA000 && addr < 16'hC000) begin
               bank = konami_m[2];
            end
            offs = (bank & (size * 2 - 1)) * 22'h2000 + addr[12:0];
         end
         MAPPER_ASCII8: begin
            mapped = addr >= 16'h4000 && addr < 16'hC000;
            bank   = ascii8_m[((addr - 16'h4000) >> 13) & 3];
            offs   = (bank & (size * 2 - 1)) * 22'h2000 + addr[12:0];
         end
         default: offs = '0;
      endcase
      exp_addr = rw[7:0] * 22'h4000 + offs;
      exp_ce   = mreq && (rd || (wr && !rw[16])) && (mtype != MAPPER_UNUSED)
               && mapped && !exp_acc;
      if (exp_acc && rd) begin
         exp_din = ~sub_m[slot];
      end else if (exp_ce && rd) begin
         exp_din = mem_hash(exp_addr);
      end else begin
         exp_din = 8'hFF;
      end

      #SAMPLE_DELAY;
      check_value("ram_ce", ram_ce, exp_ce);
      check_value("ram_we", ram_we, exp_ce && wr);
      check_value("cpu_din", cpu_din, exp_din);
      if (exp_ce) begin
         check_value("ram_addr", ram_addr, exp_addr);
      end
      if (exp_ce && wr) begin
         check_value("ram_din", ram_din, data);
      end

      // registers take the write at the coming edge
      if (exp_acc && wr) begin
         sub_m[slot] = data;
      end
      if (mreq && wr && mtype == MAPPER_KONAMI) begin
         if (addr >= 16'h6000 && addr < 16'h8000) begin
            konami_m[0] = data;
         end else if (addr >= 16'h8000 && addr < 16'hA000) begin
            konami_m[1] = data;
         end else if (addr >= 16'hA000 && addr < 16'hC000) begin
            konami_m[2] = data;
         end
      end
      if (mreq && wr && mtype == MAPPER_ASCII8 && addr >= 16'h6000 && addr < 16'h8000) begin
         ascii8_m[(addr - 16'h6000) >> 11] = data;
      end
   endtask

   initial begin
      seed        = 32'h5d8ed2e8;
      checks      = 0;
      errors      = 0;
      clk         = 1'b0;
      reset       = 1'b1;
      active_slot = 2'd0;
      expander_en = 4'b0010;
      cpu_addr    = 16'h0000;
      cpu_dout    = 8'h00;
      cpu_wr      = 1'b0;
      cpu_rd      = 1'b0;
      cpu_mreq    = 1'b0;
      cfg_wr      = 1'b0;
      cfg_region  = 1'b0;
      cfg_index   = 6'd0;
      cfg_data    = '0;
      for (i = 0; i < 4; i++) begin
         sub_m[i]    = 8'h00;
         ascii8_m[i] = 8'h00;
      end
      for (i = 0; i < 3; i++) begin
         konami_m[i] = 8'h00;
      end

      wait_clocks(3);
      #DRIVE_DELAY;
      reset = 1'b0;

      // regions {ro, size, base}: ram, rom, konami rom, ascii8 rom
      load_entry(1'b1, 6'd0, {1'b0, 8'd2, 8'h00});
      load_entry(1'b1, 6'd1, {1'b1, 8'd2, 8'h10});
      load_entry(1'b1, 6'd2, {1'b1, 8'd8, 8'h40});
      load_entry(1'b1, 6'd3, {1'b1, 8'd16, 8'h80});
      // slot 0 plain and linear, slot 1 expanded random, 2 konami, 3 ascii8
      for (i = 0; i < 64; i++) begin
         idx  = i;
         word = {MAPPER_UNUSED, 2'd0, 2'd0};
         case (idx[5:4])
            2'd0: begin
               if (idx[3:2] == 2'd0 && idx[1:0] == 2'd0) word = {MAPPER_NONE, 2'd1, 2'd0};
               if (idx[3:2] == 2'd0 && idx[1:0] == 2'd1) word = {MAPPER_NONE, 2'd1, 2'd1};
               if (idx[3:2] == 2'd0 && idx[1:0] == 2'd2) word = {MAPPER_LINEAR, 2'd0, 2'd0};
            end
            2'd1: begin
               rnd  = $random(seed);
               word = {3'($unsigned(rnd) % 5), rnd[7:4]};
            end
            2'd2:    word = {MAPPER_KONAMI, 2'd2, 2'd0};
            default: word = {MAPPER_ASCII8, 2'd3, 2'd0};
         endcase
         load_entry(1'b0, idx, region_word_t'(word));
      end

      start_test();
      access(2'd0, 16'h4000, 8'h00, 1'b0, 1'b1, 1'b0);
      access(2'd1, 16'h8123, 8'h55, 1'b1, 1'b0, 1'b0);
      access(2'd1, 16'hFFFF, 8'h00, 1'b0, 1'b1, 1'b1);
      check_value("cpu_din", cpu_din, 8'hFF);
      finish_test(1, "reset and idle");

      start_test();
      for (n = 0; n < 4; n++) begin
         rnd = $random(seed);
         access(2'd1, 16'hFFFF, rnd[7:0], 1'b1, 1'b0, 1'b1);
         access(2'd1, 16'hFFFF, 8'h00, 1'b0, 1'b1, 1'b1);
         for (i = 0; i < 12; i++) begin
            rnd = $random(seed);
            access(2'd1, rnd[15:0], rnd[23:16], rnd[31], !rnd[31], 1'b1);
         end
      end
      finish_test(2, "subslot expander");

      start_test();
      for (i = 0; i < 40; i++) begin
         rnd = $random(seed);
         a   = rnd[15:0];
         if (a[15:14] == 2'b11) a[14] = 1'b0;
         access(2'd0, a, rnd[23:16], rnd[31], !rnd[31], 1'b1);
      end
      finish_test(3, "plain and linear");

      start_test();
      for (i = 0; i < 60; i++) begin
         rnd = $random(seed);
         access(2'd2, 16'h4000 + (rnd[15:0] & 16'h7FFF), rnd[23:16], rnd[31], !rnd[31], 1'b1);
      end
      finish_test(4, "konami banks");

      start_test();
      for (i = 0; i < 60; i++) begin
         rnd = $random(seed);
         w   = rnd[31];
         a   = w ? (16'h6000 | rnd[12:0]) : (16'h4000 + (rnd[15:0] & 16'h7FFF));
         access(2'd3, a, rnd[23:16], w, !w, 1'b1);
      end
      finish_test(5, "ascii8 banks");

      start_test();
      for (i = 0; i < 24; i++) begin
         rnd = $random(seed);
         // slot 0 has only block 3 unused
         a   = {(rnd[20] || rnd[22:21] == 2'd0) ? 2'b11 : 2'b00, rnd[13:0]};
         access(rnd[22:21] == 2'd0 ? 2'd0 : {1'b1, rnd[21]}, a, 8'h00, 1'b0, 1'b1, 1'b1);
         check_value("cpu_din", cpu_din, 8'hFF);
         check_value("ram_ce", ram_ce, 1'b0);
      end
      finish_test(6, "unmapped and unused");

      $display("tests done: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- include/msx_defines.svh
`ifndef MSX_DEFINES_SVH
`define MSX_DEFINES_SVH

// external memory, 4 MB flat
`define MSX_RAM_AW            22

// 16 kB cpu blocks and 8 kB cartridge banks
`define MSX_BLOCK_SHIFT       14
`define MSX_BANK_SHIFT        13

`define MSX_EXPANDER_ADDR     16'hFFFF
`define MSX_UNMAPPED_DATA     8'hFF

// layout word: mapper, region ref, block offset
`define MSX_LAYOUT_W          7
`define MSX_LAYOUT_MAPPER_LSB 4
`define MSX_LAYOUT_REF_LSB    2
`define MSX_LAYOUT_OFFSET_LSB 0

// region word: ro flag on top, then size and base
`define MSX_REGION_W          17
`define MSX_REGION_BASE_LSB   0
`define MSX_REGION_SIZE_LSB   8
`define MSX_REGION_RO_BIT     16

`endif

//--- sim.f
+incdir+include
verilog/msx_pkg.sv
verilog/subslot_expander.sv
verilog/slot_layout_decode.sv
verilog/cart_konami.sv
verilog/cart_ascii8.sv
verilog/msx_slots.sv
bench/msx_slots_props.sv
bench/msx_slots_tb.sv

//--- verilog/cart_ascii8.sv
`timescale 1ns/1ps
`default_nettype none

`include "msx_defines.svh"

module cart_ascii8
   import msx_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        cs,
   input  logic [15:0] cpu_addr,
   input  logic [7:0]  cpu_dout,
   input  logic        wr,
   input  blocks_t     region_size,
   output ram_addr_t   mem_addr,
   output logic        unmapped
);

   bank_t      bank [0:3];
   bank_t      cur_bank;
   bank_t      bank_mask;
   logic [2:0] win_raw;
   logic [1:0] win;
   logic       in_range;
   logic       reg_hit;

   assign in_range = (cpu_addr[15:14] == 2'b01) || (cpu_addr[15:14] == 2'b10);
   assign unmapped = cs && !in_range;

   // register area 6000-7fff, 2k per bank
   assign reg_hit = cpu_addr[15:13] == 3'b011;

   always_ff @(posedge clk) begin
      if (reset) begin
         bank[0] <= 8'h00;
         bank[1] <= 8'h00;
         bank[2] <= 8'h00;
         bank[3] <= 8'h00;
      end else if (cs && wr && reg_hit) begin
         bank[cpu_addr[12:11]] <= cpu_dout;
      end
   end

   // window 4000 -> bank 0 ... a000 -> bank 3
   assign win_raw  = cpu_addr[15:13] - 3'd2;
   assign win      = win_raw[1:0];
   assign cur_bank = bank[win];

   assign bank_mask = {region_size[6:0], 1'b0} - 8'd1;

   assign mem_addr = ram_addr_t'({cur_bank & bank_mask, cpu_addr[`MSX_BANK_SHIFT-1:0]});

endmodule

`default_nettype wire

//--- verilog/cart_konami.sv
`timescale 1ns/1ps
`default_nettype none

`include "msx_defines.svh"

module cart_konami
   import msx_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        cs,
   input  logic [15:0] cpu_addr,
   input  logic [7:0]  cpu_dout,
   input  logic        wr,
   input  blocks_t     region_size,
   output ram_addr_t   mem_addr,
   output logic        unmapped
);

   // switchable banks for 6000, 8000 and a000
   bank_t bank [0:2];
   bank_t cur_bank;
   bank_t bank_mask;
   logic  in_range;

   // only 4000-bfff is decoded
   assign in_range = (cpu_addr[15:14] == 2'b01) || (cpu_addr[15:14] == 2'b10);
   assign unmapped = cs && !in_range;

   always_ff @(posedge clk) begin
      if (reset) begin
         bank[0] <= 8'h00;
         bank[1] <= 8'h00;
         bank[2] <= 8'h00;
      end else if (cs && wr) begin
         case (cpu_addr[15:13])
            3'b011:  bank[0] <= cpu_dout;
            3'b100:  bank[1] <= cpu_dout;
            3'b101:  bank[2] <= cpu_dout;
            default: ;
         endcase
      end
   end

   // 4000-5fff is hardwired to bank 0
   always_comb begin
      case (cpu_addr[15:13])
         3'b011:  cur_bank = bank[0];
         3'b100:  cur_bank = bank[1];
         3'b101:  cur_bank = bank[2];
         default: cur_bank = 8'h00;
      endcase
   end

   // two 8k banks per 16k block of the region
   assign bank_mask = {region_size[6:0], 1'b0} - 8'd1;

   assign mem_addr = ram_addr_t'({cur_bank & bank_mask, cpu_addr[`MSX_BANK_SHIFT-1:0]});

endmodule

`default_nettype wire

//--- verilog/msx_pkg.sv
`default_nettype none

`include "msx_defines.svh"

package msx_pkg;

   // mapper kinds held in the layout table
   typedef enum logic [2:0] {
      MAPPER_UNUSED = 3'd0,
      MAPPER_NONE   = 3'd1,
      MAPPER_LINEAR = 3'd2,
      MAPPER_KONAMI = 3'd3,
      MAPPER_ASCII8 = 3'd4
   } mapper_t;

   typedef logic [`MSX_RAM_AW-1:0] ram_addr_t;

   // counts and bases in 16 kB units
   typedef logic [7:0] blocks_t;

   typedef logic [7:0] bank_t;

   typedef logic [`MSX_LAYOUT_W-1:0] layout_word_t;
   typedef logic [`MSX_REGION_W-1:0] region_word_t;

endpackage

`default_nettype wire

//--- verilog/msx_slots.sv
`timescale 1ns/1ps
`default_nettype none

`include "msx_defines.svh"

module msx_slots
   import msx_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic [1:0]   active_slot,
   input  logic [3:0]   expander_en,
   input  logic [15:0]  cpu_addr,
   input  logic [7:0]   cpu_dout,
   input  logic         cpu_wr,
   input  logic         cpu_rd,
   input  logic         cpu_mreq,
   output logic [7:0]   cpu_din,
   input  logic         cfg_wr,
   input  logic         cfg_region,
   input  logic [5:0]   cfg_index,
   input  region_word_t cfg_data,
   output ram_addr_t    ram_addr,
   output logic [7:0]   ram_din,
   input  logic [7:0]   ram_dout,
   output logic         ram_ce,
   output logic         ram_we
);

   logic [1:0] subslot;
   logic       exp_sel;
   logic [7:0] exp_dout;
   logic [1:0] block;

   mapper_t    mapper;
   blocks_t    region_base;
   blocks_t    region_size;
   logic       region_ro;
   logic [1:0] block_offset;

   ram_addr_t  konami_addr;
   ram_addr_t  ascii8_addr;
   logic       konami_unmapped;
   logic       ascii8_unmapped;

   ram_addr_t  none_addr;
   ram_addr_t  linear_addr;
   ram_addr_t  mapper_addr;
   logic       mem_unmapped;
   logic       mem_wr;

   assign block  = cpu_addr[15:`MSX_BLOCK_SHIFT];
   assign mem_wr = cpu_mreq && cpu_wr;

   subslot_expander i_subslot_expander (
      .clk         (clk),
      .reset       (reset),
      .expander_en (expander_en),
      .active_slot (active_slot),
      .cpu_addr    (cpu_addr),
      .cpu_dout    (cpu_dout),
      .cpu_wr      (cpu_wr),
      .cpu_rd      (cpu_rd),
      .cpu_mreq    (cpu_mreq),
      .subslot     (subslot),
      .exp_sel     (exp_sel),
      .exp_dout    (exp_dout)
   );

   slot_layout_decode i_slot_layout_decode (
      .clk          (clk),
      .cfg_wr       (cfg_wr),
      .cfg_region   (cfg_region),
      .cfg_index    (cfg_index),
      .cfg_data     (cfg_data),
      .active_slot  (active_slot),
      .subslot      (subslot),
      .block        (block),
      .mapper       (mapper),
      .region_base  (region_base),
      .region_size  (region_size),
      .region_ro    (region_ro),
      .block_offset (block_offset)
   );

   cart_konami i_cart_konami (
      .clk         (clk),
      .reset       (reset),
      .cs          (mapper == MAPPER_KONAMI),
      .cpu_addr    (cpu_addr),
      .cpu_dout    (cpu_dout),
      .wr          (mem_wr),
      .region_size (region_size),
      .mem_addr    (konami_addr),
      .unmapped    (konami_unmapped)
   );

   cart_ascii8 i_cart_ascii8 (
      .clk         (clk),
      .reset       (reset),
      .cs          (mapper == MAPPER_ASCII8),
      .cpu_addr    (cpu_addr),
      .cpu_dout    (cpu_dout),
      .wr          (mem_wr),
      .region_size (region_size),
      .mem_addr    (ascii8_addr),
      .unmapped    (ascii8_unmapped)
   );

   // plain rom, offset picks the 16k block inside the region
   assign none_addr = ram_addr_t'({block_offset, cpu_addr[`MSX_BLOCK_SHIFT-1:0]});

   // linear, full cpu address wrapped to region size
   assign linear_addr = ram_addr_t'(cpu_addr)
                      & ((ram_addr_t'(region_size) << `MSX_BLOCK_SHIFT) - ram_addr_t'(1));

   always_comb begin
      case (mapper)
         MAPPER_NONE:   mapper_addr = none_addr;
         MAPPER_LINEAR: mapper_addr = linear_addr;
         MAPPER_KONAMI: mapper_addr = konami_addr;
         MAPPER_ASCII8: mapper_addr = ascii8_addr;
         default:       mapper_addr = '0;
      endcase
   end

   // the cart modules only flag while selected
   assign mem_unmapped = konami_unmapped || ascii8_unmapped;

   assign ram_addr = (ram_addr_t'(region_base) << `MSX_BLOCK_SHIFT) + mapper_addr;
   assign ram_din  = cpu_dout;

   assign ram_ce = cpu_mreq && (cpu_rd || (cpu_wr && !region_ro))
                && (mapper != MAPPER_UNUSED) && !mem_unmapped && !exp_sel;
   assign ram_we = ram_ce && cpu_wr;

   // idle sources drive FF, so the merge is a plain AND
   assign cpu_din = exp_dout & ((ram_ce && cpu_rd) ? ram_dout : `MSX_UNMAPPED_DATA);

endmodule

`default_nettype wire

//--- verilog/slot_layout_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "msx_defines.svh"

module slot_layout_decode
   import msx_pkg::*;
(
   input  logic         clk,
   input  logic         cfg_wr,
   input  logic         cfg_region,
   input  logic [5:0]   cfg_index,
   input  region_word_t cfg_data,
   input  logic [1:0]   active_slot,
   input  logic [1:0]   subslot,
   input  logic [1:0]   block,
   output mapper_t      mapper,
   output blocks_t      region_base,
   output blocks_t      region_size,
   output logic         region_ro,
   output logic [1:0]   block_offset
);

   // 4 slots x 4 subslots x 4 blocks
   layout_word_t layout_tab [0:63];
   region_word_t region_tab [0:3];

   layout_word_t layout_word;
   region_word_t region_word;
   logic [1:0]   region_ref;
   logic [5:0]   layout_id;

   always_ff @(posedge clk) begin
      if (cfg_wr) begin
         if (cfg_region) begin
            region_tab[cfg_index[1:0]] <= cfg_data;
         end else begin
            layout_tab[cfg_index] <= cfg_data[`MSX_LAYOUT_W-1:0];
         end
      end
   end

   assign layout_id   = {active_slot, subslot, block};
   assign layout_word = layout_tab[layout_id];

   assign mapper       = mapper_t'(layout_word[`MSX_LAYOUT_MAPPER_LSB +: 3]);
   assign region_ref   = layout_word[`MSX_LAYOUT_REF_LSB +: 2];
   assign block_offset = layout_word[`MSX_LAYOUT_OFFSET_LSB +: 2];

   // region attributes follow the reference of this block
   assign region_word = region_tab[region_ref];
   assign region_base = region_word[`MSX_REGION_BASE_LSB +: 8];
   assign region_size = region_word[`MSX_REGION_SIZE_LSB +: 8];
   assign region_ro   = region_word[`MSX_REGION_RO_BIT];

endmodule

`default_nettype wire

//--- verilog/subslot_expander.sv
`timescale 1ns/1ps
`default_nettype none

`include "msx_defines.svh"

module subslot_expander (
   input  logic       clk,
   input  logic       reset,
   input  logic [3:0] expander_en,
   input  logic [1:0] active_slot,
   input  logic [15:0] cpu_addr,
   input  logic [7:0] cpu_dout,
   input  logic       cpu_wr,
   input  logic       cpu_rd,
   input  logic       cpu_mreq,
   output logic [1:0] subslot,
   output logic       exp_sel,
   output logic [7:0] exp_dout
);

   // one secondary slot register per primary slot
   logic [7:0] sub_reg [0:3];
   logic [7:0] cur_reg;
   logic [1:0] block;

   assign cur_reg = sub_reg[active_slot];
   assign block   = cpu_addr[15:`MSX_BLOCK_SHIFT];

   assign exp_sel = cpu_mreq && (cpu_addr == `MSX_EXPANDER_ADDR) && expander_en[active_slot];

   always_ff @(posedge clk) begin
      if (reset) begin
         sub_reg[0] <= 8'h00;
         sub_reg[1] <= 8'h00;
         sub_reg[2] <= 8'h00;
         sub_reg[3] <= 8'h00;
      end else if (exp_sel && cpu_wr) begin
         sub_reg[active_slot] <= cpu_dout;
      end
   end

   // two bits per 16k block, slot without expander sits on subslot 0
   assign subslot = expander_en[active_slot] ? cur_reg[{block, 1'b0} +: 2] : 2'd0;

   // readback is inverted, idle value lets the top AND the sources
   assign exp_dout = (exp_sel && cpu_rd) ? ~cur_reg : `MSX_UNMAPPED_DATA;

endmodule

`default_nettype wire
